//--- source/bus_map_pkg.sv
// 6809 bus map package with the bus widths and the fixed memory map
package bus_map_pkg;

    typedef logic [15:0] addr_t;        // CPU address
    typedef logic [7:0]  data_t;        // Bus byte
    typedef logic [23:0] flash_addr_t;  // SPI flash byte address

    // 4 KB SRAM at the bottom of the map
    localparam addr_t SRAM_BASE = 16'h0000;
    localparam addr_t SRAM_LAST = 16'h0FFF;  // Must stay a power-of-two block

    localparam addr_t ROM_BASE  = 16'hF000;  // ROM up to the vectors
    localparam addr_t UART_BASE = 16'hA000;  // Start of the I/O area

    // UART register offsets from UART_BASE
    localparam addr_t UART_DATA_OFS = 16'd0;  // RX read, TX write
    localparam addr_t UART_STAT_OFS = 16'd1;  // Status, read only
    localparam addr_t UART_CTRL_OFS = 16'd2;  // Control, read and write

endpackage

//--- source/periph_pkg.sv
// Peripheral package with UART register bits, flash command and FSM states
package periph_pkg;

    localparam logic [7:0] FLASH_READ_CMD = 8'h03;  // Slow read, no dummy byte

    // Status register bits
    localparam int STAT_RX_VALID = 0;
    localparam int STAT_TX_BUSY  = 1;
    localparam int STAT_OVERRUN  = 2;

    localparam int CTRL_RX_IRQ_EN = 0;  // Control register bit

    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_e;

endpackage

//--- source/dec_sel_if.sv
// Region select bundle from the address decoder to the peripherals
`timescale 1ns/10ps
interface dec_sel_if;

    logic sram_sel;       // SRAM region, E high
    logic rom_sel;        // ROM region, E high
    logic uart_data_sel;  // UART data register
    logic uart_stat_sel;  // UART status register
    logic uart_ctrl_sel;  // UART control register
    logic rd;             // R/W high with a select active

    modport decoder (
        output sram_sel, rom_sel, uart_data_sel, uart_stat_sel, uart_ctrl_sel, rd
    );

    modport periph (
        input sram_sel, rom_sel, uart_data_sel, uart_stat_sel, uart_ctrl_sel, rd
    );

    modport monitor (
        input sram_sel, rom_sel, uart_data_sel, uart_stat_sel, uart_ctrl_sel, rd
    );

endinterface

//--- source/address_decoder.sv
// Address decoder, turns the 6809 address in the E phase into region selects and SRAM strobes
`timescale 1ns/10ps
module address_decoder (
    input  bus_map_pkg::addr_t i_address,
    input  logic               i_rw,
    input  logic               i_e,
    input  logic               i_q,
    dec_sel_if.decoder         sel,
    output logic               o_sram_ce_n,
    output logic               o_sram_we_n,
    output logic               o_sram_oe_n
);
    import bus_map_pkg::*;

    logic in_sram;
    logic in_rom;
    logic any_sel;

    assign in_sram = (i_address & ~(SRAM_LAST - SRAM_BASE)) == SRAM_BASE;  // Block match
    assign in_rom  = (i_address >= ROM_BASE);                             // Top 4 KB

    // Selects follow E directly
    assign sel.sram_sel      = i_e & in_sram;
    assign sel.rom_sel       = i_e & in_rom;
    assign sel.uart_data_sel = i_e & (i_address == UART_BASE + UART_DATA_OFS);
    assign sel.uart_stat_sel = i_e & (i_address == UART_BASE + UART_STAT_OFS);
    assign sel.uart_ctrl_sel = i_e & (i_address == UART_BASE + UART_CTRL_OFS);

    assign any_sel = sel.sram_sel | sel.rom_sel | sel.uart_data_sel | sel.uart_stat_sel
                   | sel.uart_ctrl_sel;
    assign sel.rd  = i_rw & any_sel;

    assign o_sram_ce_n = ~sel.sram_sel;
    assign o_sram_oe_n = ~(sel.sram_sel & i_rw);
    assign o_sram_we_n = ~(sel.sram_sel & ~i_rw & ~i_q);  // Late E quarter, write data valid

    // The map regions must never overlap, checked mid E phase
    a_one_sel : assert property (@(negedge i_q)
        $onehot0({sel.sram_sel, sel.rom_sel, sel.uart_data_sel, sel.uart_stat_sel,
                  sel.uart_ctrl_sel}));

endmodule

//--- source/spi_rom_reader.sv
// SPI flash ROM reader, fetches the addressed byte and stalls the CPU with MRDY
`timescale 1ns/10ps
module spi_rom_reader #(
    parameter bus_map_pkg::flash_addr_t FLASH_BASE = '0
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    dec_sel_if.periph          sel,
    input  bus_map_pkg::addr_t i_address,
    input  logic               i_spi_miso,
    output logic               o_spi_clk,
    output logic               o_spi_mosi,
    output logic               o_spi_cs_n,
    output bus_map_pkg::data_t o_rom_data,
    output logic               o_rom_ready,
    output logic               o_mrdy
);
    import bus_map_pkg::*;
    import periph_pkg::*;

    localparam logic [5:0] LAST_BIT = 6'd39;  // 8 cmd + 24 addr + 8 data

    spi_state_e  state;
    logic [31:0] cmd_shreg;   // Command then address, MSB first
    data_t       rx_shreg;
    logic [5:0]  bit_cnt;
    flash_addr_t flash_addr;
    logic        start;

    assign flash_addr  = FLASH_BASE + flash_addr_t'(i_address[11:0]);  // 4 KB window
    assign start       = sel.rom_sel & sel.rd;                          // ROM writes ignored
    assign o_spi_mosi  = cmd_shreg[31] & ~o_spi_cs_n;                   // Quiet when idle
    assign o_rom_ready = (state == SPI_DONE);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state      <= SPI_IDLE;
            o_spi_clk  <= 1'b0;
            o_spi_cs_n <= 1'b1;
            o_mrdy     <= 1'b1;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        cmd_shreg  <= {FLASH_READ_CMD, flash_addr};
                        bit_cnt    <= '0;
                        o_spi_cs_n <= 1'b0;
                        o_mrdy     <= 1'b0;  // Stretch E from the next cycle
                        state      <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT: begin
                    if (!o_spi_clk) begin
                        o_spi_clk <= 1'b1;  // Rising edge, flash samples MOSI
                    end else begin
                        o_spi_clk <= 1'b0;  // Falling edge, next MOSI bit
                        cmd_shreg <= {cmd_shreg[30:0], 1'b0};
                        rx_shreg  <= {rx_shreg[6:0], i_spi_miso};  // MISO stable over high phase
                        bit_cnt   <= bit_cnt + 6'd1;
                        if (bit_cnt == LAST_BIT) begin
                            o_rom_data <= {rx_shreg[6:0], i_spi_miso};
                            o_spi_cs_n <= 1'b1;
                            o_mrdy     <= 1'b1;
                            state      <= SPI_DONE;
                        end
                    end
                end
                SPI_DONE: begin
                    if (!sel.rom_sel) begin
                        state <= SPI_IDLE;  // E fell, rearm
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    a_cs_busy : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !o_spi_cs_n |-> state != SPI_IDLE);

    a_mrdy_idle : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state == SPI_IDLE |-> o_mrdy);

endmodule

//--- source/uart_core.sv
// UART with data, status and control registers, 8N1 transmitter and receiver, RX interrupt
`timescale 1ns/10ps
module uart_core #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               i_clk,
    input  logic               i_rst_n,
    dec_sel_if.periph          sel,
    input  bus_map_pkg::data_t i_wdata,
    output bus_map_pkg::data_t o_uart_rdata,
    input  logic               i_uart_rx,
    output logic               o_uart_tx,
    output logic               o_irq
);
    import bus_map_pkg::*;
    import periph_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);

    uart_tx_state_e   tx_state;
    uart_rx_state_e   rx_state;
    logic [CNT_W-1:0] tx_cnt;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0]       tx_bit;
    logic [2:0]       rx_bit;
    data_t            tx_shreg;
    data_t            rx_shreg;
    data_t            rx_data;
    data_t            ctrl_q;
    logic             rx_valid;
    logic             overrun;
    logic             rx_s1;
    logic             rx_s2;
    logic             uart_sel;
    logic             sel_q;
    logic             wr_stb;
    logic             rd_data_q;
    logic             rd_stat_q;
    logic             rx_done;

    assign uart_sel = sel.uart_data_sel | sel.uart_stat_sel | sel.uart_ctrl_sel;
    assign wr_stb   = uart_sel & ~sel.rd & ~sel_q;  // One write per E phase
    assign rx_done  = (rx_state == RX_STOP) && (rx_cnt == BIT_LAST) && rx_s2;
    assign o_irq    = rx_valid & ctrl_q[CTRL_RX_IRQ_EN];

    always_comb begin
        o_uart_rdata = '0;
        if (sel.uart_data_sel) begin
            o_uart_rdata = rx_data;
        end else if (sel.uart_stat_sel) begin
            o_uart_rdata[STAT_RX_VALID] = rx_valid;
            o_uart_rdata[STAT_TX_BUSY]  = (tx_state != TX_IDLE);
            o_uart_rdata[STAT_OVERRUN]  = overrun;
        end else if (sel.uart_ctrl_sel) begin
            o_uart_rdata = ctrl_q;
        end
    end

    // Register block with read side effects landing when E falls
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            sel_q     <= 1'b0;
            rd_data_q <= 1'b0;
            rd_stat_q <= 1'b0;
            ctrl_q    <= '0;
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            sel_q     <= uart_sel;
            rd_data_q <= sel.uart_data_sel & sel.rd;
            rd_stat_q <= sel.uart_stat_sel & sel.rd;
            if (wr_stb && sel.uart_ctrl_sel) begin
                ctrl_q <= i_wdata;
            end
            if (rx_done) begin
                rx_valid <= 1'b1;  // New byte wins over a clear
            end else if (rd_data_q && !sel.uart_data_sel) begin
                rx_valid <= 1'b0;
            end
            if (rx_done && rx_valid) begin
                overrun <= 1'b1;  // Previous byte never read
            end else if (rd_stat_q && !sel.uart_stat_sel) begin
                overrun <= 1'b0;
            end
        end
    end

    // Transmitter shifts LSB first
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            tx_state  <= TX_IDLE;
            o_uart_tx <= 1'b1;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    o_uart_tx <= 1'b1;
                    if (wr_stb && sel.uart_data_sel) begin  // Busy writes never get here
                        tx_shreg  <= i_wdata;
                        tx_cnt    <= '0;
                        o_uart_tx <= 1'b0;  // Start bit
                        tx_state  <= TX_START;
                    end
                end
                TX_START: begin
                    tx_cnt <= tx_cnt + CNT_W'(1);
                    if (tx_cnt == BIT_LAST) begin
                        tx_cnt    <= '0;
                        tx_bit    <= '0;
                        o_uart_tx <= tx_shreg[0];
                        tx_state  <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    tx_cnt <= tx_cnt + CNT_W'(1);
                    if (tx_cnt == BIT_LAST) begin
                        tx_cnt   <= '0;
                        tx_shreg <= {1'b0, tx_shreg[7:1]};
                        tx_bit   <= tx_bit + 3'd1;
                        o_uart_tx <= tx_shreg[1];
                        if (tx_bit == 3'd7) begin
                            o_uart_tx <= 1'b1;  // Stop bit
                            tx_state  <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    tx_cnt <= tx_cnt + CNT_W'(1);
                    if (tx_cnt == BIT_LAST) begin
                        tx_state <= TX_IDLE;
                    end
                end
                default: tx_state <= TX_IDLE;
            endcase
        end
    end

    // Receiver samples mid-bit behind a two-flop synchronizer
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_state <= RX_IDLE;
        end else begin
            rx_s1  <= i_uart_rx;
            rx_s2  <= rx_s1;
            rx_cnt <= rx_cnt + CNT_W'(1);
            case (rx_state)
                RX_IDLE: begin
                    rx_cnt <= '0;
                    if (!rx_s2) begin
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt == HALF_LAST) begin
                        rx_cnt   <= '0;
                        rx_bit   <= '0;
                        rx_state <= rx_s2 ? RX_IDLE : RX_DATA;  // Glitch check
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_LAST) begin
                        rx_cnt   <= '0;
                        rx_shreg <= {rx_s2, rx_shreg[7:1]};
                        rx_bit   <= rx_bit + 3'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (rx_cnt == BIT_LAST) begin
                        if (rx_s2) begin
                            rx_data <= rx_shreg;  // Framing errors dropped
                        end
                        rx_state <= RX_IDLE;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

    a_tx_idle_high : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        tx_state == TX_IDLE |-> o_uart_tx);

endmodule

//--- source/mem_adapter_top.sv
// 6809 memory adapter top, joins decoder, SPI ROM and UART and merges the read data
`timescale 1ns/10ps
module mem_adapter_top #(
    parameter bus_map_pkg::flash_addr_t FLASH_BASE   = '0,
    parameter int                       CLKS_PER_BIT = 16
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [15:0] i_address,
    input  logic        i_rw,
    input  logic        i_e,
    input  logic        i_q,
    input  logic [7:0]  i_data,
    output logic [7:0]  o_data,
    output logic        o_data_oe,    // Drive the data bus
    output logic        o_dben,       // Low releases the CPU data bus
    output logic        o_mrdy,
    output logic        o_sram_ce_n,
    output logic        o_sram_we_n,
    output logic        o_sram_oe_n,
    output logic        o_spi_clk,
    output logic        o_spi_mosi,
    output logic        o_spi_cs_n,
    input  logic        i_spi_miso,
    input  logic        i_uart_rx,
    output logic        o_uart_tx,
    output logic        o_irq
);
    import bus_map_pkg::*;

    data_t rom_data;
    data_t uart_rdata;
    logic  rom_ready;
    logic  uart_sel;
    logic  any_sel;
    logic  rom_wait;

    dec_sel_if u_sel ();

    address_decoder u_dec (
        .i_address   (i_address),
        .i_rw        (i_rw),
        .i_e         (i_e),
        .i_q         (i_q),
        .sel         (u_sel.decoder),
        .o_sram_ce_n (o_sram_ce_n),
        .o_sram_we_n (o_sram_we_n),
        .o_sram_oe_n (o_sram_oe_n)
    );

    spi_rom_reader #(.FLASH_BASE(FLASH_BASE)) u_rom (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .sel         (u_sel.periph),
        .i_address   (i_address),
        .i_spi_miso  (i_spi_miso),
        .o_spi_clk   (o_spi_clk),
        .o_spi_mosi  (o_spi_mosi),
        .o_spi_cs_n  (o_spi_cs_n),
        .o_rom_data  (rom_data),
        .o_rom_ready (rom_ready),
        .o_mrdy      (o_mrdy)
    );

    uart_core #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .sel          (u_sel.periph),
        .i_wdata      (i_data),
        .o_uart_rdata (uart_rdata),
        .i_uart_rx    (i_uart_rx),
        .o_uart_tx    (o_uart_tx),
        .o_irq        (o_irq)
    );

    assign uart_sel = u_sel.uart_data_sel | u_sel.uart_stat_sel | u_sel.uart_ctrl_sel;
    assign any_sel  = u_sel.sram_sel | u_sel.rom_sel | uart_sel;
    assign rom_wait = u_sel.rom_sel & u_sel.rd & ~rom_ready;  // Flash byte still in flight

    assign o_data    = u_sel.rom_sel ? rom_data : uart_rdata;  // UART reads zero when unselected
    assign o_data_oe = u_sel.rd & (u_sel.rom_sel | uart_sel);
    assign o_dben    = ~(any_sel & ~rom_wait);

endmodule

//--- bench/mem_adapter_tasks.svh
// Bus cycle, serial line and result check tasks for the memory adapter testbench
`ifndef MEM_ADAPTER_TASKS_SVH
`define MEM_ADAPTER_TASKS_SVH

function automatic int total_errors();
    return errors + flash_errors;  // Bench checks plus flash model complaints
endfunction

task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
        $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
        errors++;
    end
endtask

task automatic check_byte(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
        $display("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests++;
    if (total_errors() == errs_before) begin
        $display("Test %0d %s: ok", tests, name);
    end else begin
        $display("Test %0d %s: %0d failing checks", tests, name, total_errors() - errs_before);
    end
endtask

// CPU write with E high for two clocks and Q high in the first one
task automatic bus_write(input addr_t addr, input data_t data);
    address = addr;
    rw      = 1'b0;
    wdata   = data;
    e       = 1'b1;
    q       = 1'b1;
    @(negedge clk);
    q = 1'b0;  // Late E quarter
    @(negedge clk);
    e  = 1'b0;
    rw = 1'b1;
    @(negedge clk);
endtask

// CPU read with E stretched for as long as MRDY is low
task automatic bus_read(input addr_t addr, output data_t data, output logic oe,
                        output logic mrdy_first);
    int wait_cnt;
    address = addr;
    rw      = 1'b1;
    e       = 1'b1;
    q       = 1'b1;
    @(negedge clk);
    mrdy_first    = mrdy;  // Low here when a flash fetch started
    dben_at_start = dben;
    q             = 1'b0;
    wait_cnt      = 0;
    while (!mrdy && wait_cnt < MRDY_TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
    end
    if (!mrdy) begin
        $display("MRDY stayed low for %0d cycles on a read of 0x%04h", wait_cnt, addr);
        errors++;
    end
    data         = rdata;
    oe           = data_oe;
    dben_at_data = dben;
    e            = 1'b0;
    @(negedge clk);  // Read side effects land here
endtask

// SRAM cycle with the strobes derived from the map and R/W
task automatic sram_access(input addr_t addr, input logic rd);
    logic hit;
    hit     = (addr <= 16'h0FFF);
    address = addr;
    rw      = rd;
    wdata   = 8'hC3;
    e       = 1'b1;
    q       = 1'b1;
    @(negedge clk);
    check_bit("o_sram_ce_n", sram_ce_n, !hit);
    check_bit("o_sram_oe_n", sram_oe_n, !(hit && rd));
    check_bit("o_sram_we_n", sram_we_n, 1'b1);  // Write data not valid while Q is high
    check_bit("o_dben", dben, !hit);
    check_bit("o_data_oe", data_oe, 1'b0);
    q = 1'b0;
    @(negedge clk);
    check_bit("o_sram_we_n", sram_we_n, !(hit && !rd));
    check_bit("o_sram_ce_n", sram_ce_n, !hit);
    e  = 1'b0;
    rw = 1'b1;
    @(negedge clk);
    check_bit("o_sram_ce_n", sram_ce_n, 1'b1);
    check_bit("o_dben", dben, 1'b1);
endtask

// 8N1 frame into the receiver with LSB first
task automatic send_serial(input data_t b);
    data_t sh;
    sh      = b;
    uart_rx = 1'b0;
    repeat (BIT_CLKS) @(negedge clk);
    repeat (8) begin
        uart_rx = sh[0];
        sh      = sh >> 1;
        repeat (BIT_CLKS) @(negedge clk);
    end
    uart_rx = 1'b1;  // Stop bit then idle line
    repeat (BIT_CLKS) @(negedge clk);
endtask

// Finds the start bit and then samples every bit in its middle
task automatic check_tx_frame(input data_t b);
    int    wait_cnt;
    data_t sh;
    wait_cnt = 0;
    while (uart_tx && wait_cnt < LINE_TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
    end
    if (uart_tx) begin
        $display("No start bit on o_uart_tx within %0d cycles", LINE_TIMEOUT);
        errors++;
    end else begin
        repeat (BIT_CLKS / 2) @(negedge clk);
        check_bit("o_uart_tx", uart_tx, 1'b0);
        sh = b;
        repeat (8) begin
            repeat (BIT_CLKS) @(negedge clk);
            check_bit("o_uart_tx", uart_tx, sh[0]);
            sh = sh >> 1;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_bit("o_uart_tx", uart_tx, 1'b1);
    end
endtask

task automatic wait_irq();
    int wait_cnt;
    wait_cnt = 0;
    while (!irq && wait_cnt < LINE_TIMEOUT) begin
        @(negedge clk);
        wait_cnt++;
    end
    if (!irq) begin
        $display("o_irq did not rise within %0d cycles of the received byte", LINE_TIMEOUT);
        errors++;
    end
endtask

// Polls the status register until the masked bits reach the wanted level
task automatic wait_status(input data_t mask, input logic want);
    int    polls;
    data_t stat;
    logic  oe;
    logic  mrdy_first;
    polls = 0;
    bus_read(STAT_ADDR, stat, oe, mrdy_first);
    while ((((stat & mask) != 8'h00) != want) && polls < POLL_TIMEOUT) begin
        bus_read(STAT_ADDR, stat, oe, mrdy_first);
        polls++;
    end
    if (((stat & mask) != 8'h00) != want) begin
        $display("Status bits 0x%02h did not reach %0b after %0d reads", mask, want, polls);
        errors++;
    end
endtask

`endif

//--- bench/mem_adapter_tb.sv
// Testbench for the 6809 memory adapter with a behavioral SPI flash and directed tests
`timescale 1ns/10ps
module mem_adapter_tb;
    import bus_map_pkg::*;
    import periph_pkg::*;

    localparam int          BIT_CLKS      = 8;
    localparam flash_addr_t FLASH_BASE    = 24'h010000;
    localparam int          MRDY_TIMEOUT  = 200;           // Fetch takes about 80 cycles
    localparam int          LINE_TIMEOUT  = 12 * BIT_CLKS;  // A bit more than one frame
    localparam int          POLL_TIMEOUT  = 40;            // Status reads
    localparam addr_t       DATA_ADDR     = UART_BASE + UART_DATA_OFS;
    localparam addr_t       STAT_ADDR     = UART_BASE + UART_STAT_OFS;
    localparam addr_t       CTRL_ADDR     = UART_BASE + UART_CTRL_OFS;
    localparam data_t       TX_BUSY_MASK  = data_t'(1 << STAT_TX_BUSY);
    localparam data_t       OVERRUN_MASK  = data_t'(1 << STAT_OVERRUN);

    logic        clk;
    logic        rst_n;
    addr_t       address;
    logic        rw;
    logic        e;
    logic        q;
    data_t       wdata;
    data_t       rdata;
    logic        data_oe;
    logic        dben;
    logic        mrdy;
    logic        sram_ce_n;
    logic        sram_we_n;
    logic        sram_oe_n;
    logic        spi_clk;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        spi_miso;
    logic        uart_rx;
    logic        uart_tx;
    logic        irq;
    logic        dben_at_start;       // DBEN one clock into the last read
    logic        dben_at_data;        // DBEN when the last read took its data
    integer      seed;
    int          errors;
    int          flash_errors;
    int          checks;
    int          tests;
    int          spi_cnt;             // SPI clocks since chip select fell
    logic [31:0] spi_in;              // Command and address as received
    data_t       flash_byte;          // Byte being shifted out
    flash_addr_t last_flash_addr;

    mem_adapter_top #(
        .FLASH_BASE   (FLASH_BASE),
        .CLKS_PER_BIT (BIT_CLKS)
    ) u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_address   (address),
        .i_rw        (rw),
        .i_e         (e),
        .i_q         (q),
        .i_data      (wdata),
        .o_data      (rdata),
        .o_data_oe   (data_oe),
        .o_dben      (dben),
        .o_mrdy      (mrdy),
        .o_sram_ce_n (sram_ce_n),
        .o_sram_we_n (sram_we_n),
        .o_sram_oe_n (sram_oe_n),
        .o_spi_clk   (spi_clk),
        .o_spi_mosi  (spi_mosi),
        .o_spi_cs_n  (spi_cs_n),
        .i_spi_miso  (spi_miso),
        .i_uart_rx   (uart_rx),
        .o_uart_tx   (uart_tx),
        .o_irq       (irq)
    );

    always #50 clk = ~clk;

    // SPI flash in mode 0 answering a read with the address low byte XOR 0x5A
    always @(posedge spi_clk or negedge spi_cs_n) begin
        if (!spi_clk) begin
            spi_cnt = 0;  // New transfer
            spi_in  = '0;
        end else if (!spi_cs_n) begin
            spi_cnt = spi_cnt + 1;
            if (spi_cnt <= 32) begin
                spi_in = {spi_in[30:0], spi_mosi};
            end
            if (spi_cnt == 32) begin
                last_flash_addr = spi_in[23:0];
                flash_byte      = spi_in[7:0] ^ 8'h5A;
                if (spi_in[31:24] != 8'h03) begin
                    $display("Flash model got command 0x%02h, not a read", spi_in[31:24]);
                    flash_errors++;
                end
                if (spi_in[23:12] != FLASH_BASE[23:12]) begin
                    $display("Flash address 0x%06h is outside the ROM image at 0x%06h",
                             spi_in[23:0], FLASH_BASE);
                    flash_errors++;
                end
            end else if (spi_cnt > 32) begin
                spi_miso   = flash_byte[7];  // MSB first and held over the high phase
                flash_byte = flash_byte << 1;
            end
        end
    end

    `include "mem_adapter_tasks.svh"

    task automatic test_reset();
        int errs_before;
        errs_before = total_errors();
        check_bit("o_mrdy", mrdy, 1'b1);
        check_bit("o_dben", dben, 1'b1);
        check_bit("o_data_oe", data_oe, 1'b0);
        check_bit("o_sram_ce_n", sram_ce_n, 1'b1);
        check_bit("o_spi_cs_n", spi_cs_n, 1'b1);
        check_bit("o_uart_tx", uart_tx, 1'b1);
        check_bit("o_irq", irq, 1'b0);
        report_test("reset state", errs_before);
    endtask

    task automatic test_sram_decode();
        int errs_before;
        errs_before = total_errors();
        sram_access(16'h0000, 1'b1);
        sram_access(16'h0000, 1'b0);
        sram_access(16'h0FFF, 1'b1);
        sram_access(16'h0FFF, 1'b0);
        sram_access(16'h1000, 1'b1);  // First address past the SRAM
        sram_access(16'h1000, 1'b0);
        report_test("SRAM decode", errs_before);
    endtask

    task automatic test_rom_read();
        int          errs_before;
        logic [31:0] rnd;
        addr_t       addr;
        data_t       got;
        logic        oe;
        logic        mrdy_first;
        errs_before = total_errors();
        repeat (3) begin
            rnd  = $random(seed);
            addr = {4'hF, rnd[11:0]};
            bus_read(addr, got, oe, mrdy_first);
            check_bit("o_mrdy", mrdy_first, 1'b0);
            check_bit("o_dben", dben_at_start, 1'b1);  // Flash byte still in flight
            check_bit("o_dben", dben_at_data, 1'b0);
            check_byte("o_data", got, addr[7:0] ^ 8'h5A);
            check_bit("o_data_oe", oe, 1'b1);
            checks++;
            assert (last_flash_addr == FLASH_BASE + {12'h000, addr[11:0]}) else begin
                $display("** Error: flash address = 0x%06h, expected 0x%06h",
                         last_flash_addr, FLASH_BASE + {12'h000, addr[11:0]});
                errors++;
            end
        end
        // Write into ROM space must not start a fetch
        address = ROM_BASE + 16'h0123;
        rw      = 1'b0;
        e       = 1'b1;
        q       = 1'b1;
        repeat (4) begin
            @(negedge clk);
            check_bit("o_mrdy", mrdy, 1'b1);
            check_bit("o_spi_cs_n", spi_cs_n, 1'b1);
            q = 1'b0;
        end
        e  = 1'b0;
        rw = 1'b1;
        @(negedge clk);
        report_test("ROM read", errs_before);
    endtask

    task automatic test_uart_tx();
        int          errs_before;
        logic [31:0] rnd;
        data_t       b;
        data_t       stat;
        logic        oe;
        logic        mrdy_first;
        errs_before = total_errors();
        rnd = $random(seed);
        b   = rnd[7:0];
        fork
            check_tx_frame(b);
            begin
                bus_write(DATA_ADDR, b);
                repeat (2 * BIT_CLKS) @(negedge clk);  // Well inside the frame
                bus_read(STAT_ADDR, stat, oe, mrdy_first);
                check_bit("status tx_busy", stat[STAT_TX_BUSY], 1'b1);
            end
        join
        wait_status(TX_BUSY_MASK, 1'b0);
        report_test("UART transmit", errs_before);
    endtask

    task automatic test_uart_rx();
        int          errs_before;
        logic [31:0] rnd;
        data_t       got;
        logic        oe;
        logic        mrdy_first;
        errs_before = total_errors();
        rnd = $random(seed);
        bus_write(CTRL_ADDR, 8'h01);  // RX interrupt on
        bus_read(CTRL_ADDR, got, oe, mrdy_first);
        check_byte("control register", got, 8'h01);
        send_serial(rnd[7:0]);
        wait_irq();
        bus_read(STAT_ADDR, got, oe, mrdy_first);
        check_bit("status rx_valid", got[STAT_RX_VALID], 1'b1);
        check_bit("status overrun", got[STAT_OVERRUN], 1'b0);
        bus_read(DATA_ADDR, got, oe, mrdy_first);
        check_byte("o_data", got, rnd[7:0]);
        check_bit("o_data_oe", oe, 1'b1);
        check_bit("o_dben", dben_at_data, 1'b0);
        bus_read(STAT_ADDR, got, oe, mrdy_first);
        check_bit("status rx_valid", got[STAT_RX_VALID], 1'b0);
        check_bit("o_irq", irq, 1'b0);
        // Two bytes with no read between them
        send_serial(rnd[15:8]);
        wait_irq();
        send_serial(rnd[23:16]);
        wait_status(OVERRUN_MASK, 1'b1);
        bus_read(STAT_ADDR, got, oe, mrdy_first);
        check_bit("status overrun", got[STAT_OVERRUN], 1'b0);
        check_bit("status rx_valid", got[STAT_RX_VALID], 1'b1);
        bus_read(DATA_ADDR, got, oe, mrdy_first);
        bus_read(STAT_ADDR, got, oe, mrdy_first);
        check_bit("status rx_valid", got[STAT_RX_VALID], 1'b0);
        check_bit("o_irq", irq, 1'b0);
        report_test("UART receive and interrupt", errs_before);
    endtask

    initial begin
        seed          = 32'hedd7b918;
        errors        = 0;
        flash_errors  = 0;
        checks        = 0;
        tests         = 0;
        dben_at_start = 1'b1;
        dben_at_data  = 1'b1;
        clk           = 1'b0;
        rst_n         = 1'b0;
        address       = '0;
        rw            = 1'b1;
        e             = 1'b0;
        q             = 1'b0;
        wdata         = '0;
        spi_miso      = 1'b0;
        uart_rx       = 1'b1;  // Idle line
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_sram_decode();
        test_rom_read();
        test_uart_tx();
        test_uart_rx();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, total_errors());
        if (total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- mem_adapter.f
+incdir+bench
source/bus_map_pkg.sv
source/periph_pkg.sv
source/dec_sel_if.sv
source/address_decoder.sv
source/spi_rom_reader.sv
source/uart_core.sv
source/mem_adapter_top.sv
bench/mem_adapter_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory adapter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mem_adapter_tb -f mem_adapter.f

out=$(./obj_dir/Vmem_adapter_tb)
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
